// File: hdl/rs_cfg_pkg.sv
`default_nettype none

package rs_cfg_pkg;

    // station geometry
    localparam int RS_DEPTH  = 4;  // number of slots
    localparam int CDB_WIDTH = 2;  // broadcast ports on the common data bus

    // physical register file
    localparam int PHY_REG_W = 6;

    localparam int RS_IDX_W  = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // slot index, used for the issue mux
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // physical register tag
    // tag 0 is the hardwired zero register, always ready
    typedef logic [PHY_REG_W-1:0] phy_reg_t;

endpackage

`default_nettype wire

// File: hdl/uop_pkg.sv
`default_nettype none

package uop_pkg;

    // fields of a renamed micro-op carried through the station
    localparam int ROB_TAG_W = 5;  // reorder buffer entry
    localparam int ALU_OP_W  = 4;  // alu operation code

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [ALU_OP_W-1:0]  alu_op_t;

endpackage

`default_nettype wire

// File: hdl/rs_entry.sv
`default_nettype none

module rs_entry (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  logic                                              push_en,
    input  logic                                              grant,
    input  uop_pkg::rob_tag_t                                 disp_rob_tag,
    input  uop_pkg::alu_op_t                                  disp_alu_op,
    input  rs_cfg_pkg::phy_reg_t                              disp_rs1_phy,
    input  rs_cfg_pkg::phy_reg_t                              disp_rs2_phy,
    input  logic                                              disp_rs1_ready,
    input  logic                                              disp_rs2_ready,
    input  rs_cfg_pkg::phy_reg_t                              disp_rd_phy,
    input  logic [rs_cfg_pkg::CDB_WIDTH-1:0]                  cdb_valid,
    input  rs_cfg_pkg::phy_reg_t [rs_cfg_pkg::CDB_WIDTH-1:0]  cdb_rd_phy,
    output logic                                              valid,
    output logic                                              request,
    output uop_pkg::rob_tag_t                                 rob_tag,
    output uop_pkg::alu_op_t                                  alu_op,
    output rs_cfg_pkg::phy_reg_t                              rs1_phy,
    output rs_cfg_pkg::phy_reg_t                              rs2_phy,
    output rs_cfg_pkg::phy_reg_t                              rd_phy,
    output logic                                              rs1_bypass,
    output logic                                              rs2_bypass
);

    import rs_cfg_pkg::*;
    import uop_pkg::*;

    logic     valid_q;
    logic     rs1_rdy_q;
    logic     rs2_rdy_q;
    rob_tag_t rob_tag_q;
    alu_op_t  alu_op_q;
    phy_reg_t rs1_phy_q;
    phy_reg_t rs2_phy_q;
    phy_reg_t rd_phy_q;

    logic     rs1_wake;       // live broadcast on a held source
    logic     rs2_wake;
    logic     push_rs1_wake;  // broadcast on a source being written this cycle
    logic     push_rs2_wake;

    // tag compare against every cdb port
    always_comb begin
        rs1_wake      = 1'b0;
        rs2_wake      = 1'b0;
        push_rs1_wake = 1'b0;
        push_rs2_wake = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (cdb_valid[k]) begin
                if (cdb_rd_phy[k] == rs1_phy_q) begin
                    rs1_wake = 1'b1;
                end
                if (cdb_rd_phy[k] == rs2_phy_q) begin
                    rs2_wake = 1'b1;
                end
                if (cdb_rd_phy[k] == disp_rs1_phy) begin
                    push_rs1_wake = 1'b1;
                end
                if (cdb_rd_phy[k] == disp_rs2_phy) begin
                    push_rs2_wake = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            rs1_rdy_q <= 1'b0;
            rs2_rdy_q <= 1'b0;
        end else if (push_en) begin
            valid_q   <= 1'b1;
            // zero register never waits
            rs1_rdy_q <= disp_rs1_ready || (disp_rs1_phy == '0) || push_rs1_wake;
            rs2_rdy_q <= disp_rs2_ready || (disp_rs2_phy == '0) || push_rs2_wake;
        end else begin
            if (grant) begin
                valid_q <= 1'b0;  // slot leaves on issue
            end
            rs1_rdy_q <= rs1_rdy_q || rs1_wake;
            rs2_rdy_q <= rs2_rdy_q || rs2_wake;
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            rob_tag_q <= disp_rob_tag;
            alu_op_q  <= disp_alu_op;
            rs1_phy_q <= disp_rs1_phy;
            rs2_phy_q <= disp_rs2_phy;
            rd_phy_q  <= disp_rd_phy;
        end
    end

    assign valid   = valid_q;
    assign request = valid_q && (rs1_rdy_q || rs1_wake) && (rs2_rdy_q || rs2_wake);

    // operand comes off the cdb in the issue cycle
    assign rs1_bypass = !rs1_rdy_q && rs1_wake && (rs1_phy_q != '0);
    assign rs2_bypass = !rs2_rdy_q && rs2_wake && (rs2_phy_q != '0);

    assign rob_tag = rob_tag_q;
    assign alu_op  = alu_op_q;
    assign rs1_phy = rs1_phy_q;
    assign rs2_phy = rs2_phy_q;
    assign rd_phy  = rd_phy_q;

    // allocator only targets free slots, selector only grants held ones
    a_no_push_on_grant: assert property (
        @(posedge clk) disable iff (!arst_n) !(push_en && grant)
    );

endmodule

`default_nettype wire

// File: hdl/rs_alloc.sv
`default_nettype none

module rs_alloc (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               disp_valid,
    input  logic [rs_cfg_pkg::RS_DEPTH-1:0]    slot_valid,
    output logic                               disp_ready,
    output logic [rs_cfg_pkg::RS_DEPTH-1:0]    push_en
);

    import rs_cfg_pkg::*;

    logic [RS_DEPTH-1:0] free;
    logic [RS_DEPTH-1:0] pick;  // lowest free slot, one-hot

    assign free = ~slot_valid;

    // isolate the lowest set bit of the free mask
    assign pick = free & (~free + 1'b1);

    assign disp_ready = |free;
    assign push_en    = disp_valid ? pick : '0;

    a_push_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(push_en)
    );

    // a held micro-op must never be overwritten
    a_push_free_only: assert property (
        @(posedge clk) disable iff (!arst_n) (push_en & slot_valid) == '0
    );

endmodule

`default_nettype wire

// File: hdl/rs_select.sv
`default_nettype none

module rs_select (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [rs_cfg_pkg::RS_DEPTH-1:0]    push_en,
    input  logic [rs_cfg_pkg::RS_DEPTH-1:0]    request,
    input  logic                               iss_ready,
    output logic                               iss_valid,
    output logic [rs_cfg_pkg::RS_DEPTH-1:0]    grant,
    output rs_cfg_pkg::rs_idx_t                sel_idx
);

    import rs_cfg_pkg::*;

    // older[i][j] set means slot i was written before slot j
    logic [RS_DEPTH-1:0][RS_DEPTH-1:0] older;
    logic [RS_DEPTH-1:0]               oldest;  // oldest requester, one-hot

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            older <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                for (int j = 0; j < RS_DEPTH; j++) begin
                    if (push_en[i]) begin
                        older[i][j] <= 1'b0;  // new slot is youngest
                    end else if (push_en[j]) begin
                        older[i][j] <= 1'b1;
                    end
                end
            end
        end
    end

    // a requester wins if no other requester is older
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            oldest[i] = request[i];
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (j != i && request[j] && older[j][i]) begin
                    oldest[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (oldest[i]) begin
                sel_idx = rs_idx_t'(i);
            end
        end
    end

    assign iss_valid = |request;
    assign grant     = iss_ready ? oldest : '0;  // hold everything under back-pressure

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(grant)
    );

endmodule

`default_nettype wire

// File: hdl/int_rs.sv
`default_nettype none

module int_rs (
    input  logic                                              clk,
    input  logic                                              arst_n,
    // dispatch
    input  logic                                              disp_valid,
    output logic                                              disp_ready,
    input  uop_pkg::rob_tag_t                                 disp_rob_tag,
    input  uop_pkg::alu_op_t                                  disp_alu_op,
    input  rs_cfg_pkg::phy_reg_t                              disp_rs1_phy,
    input  logic                                              disp_rs1_ready,
    input  rs_cfg_pkg::phy_reg_t                              disp_rs2_phy,
    input  logic                                              disp_rs2_ready,
    input  rs_cfg_pkg::phy_reg_t                              disp_rd_phy,
    // wakeup
    input  logic [rs_cfg_pkg::CDB_WIDTH-1:0]                  cdb_valid,
    input  rs_cfg_pkg::phy_reg_t [rs_cfg_pkg::CDB_WIDTH-1:0]  cdb_rd_phy,
    // issue to the alu
    output logic                                              iss_valid,
    input  logic                                              iss_ready,
    output uop_pkg::rob_tag_t                                 iss_rob_tag,
    output uop_pkg::alu_op_t                                  iss_alu_op,
    output rs_cfg_pkg::phy_reg_t                              iss_rs1_phy,
    output rs_cfg_pkg::phy_reg_t                              iss_rs2_phy,
    output rs_cfg_pkg::phy_reg_t                              iss_rd_phy,
    output logic                                              iss_rs1_bypass,
    output logic                                              iss_rs2_bypass
);

    import rs_cfg_pkg::*;
    import uop_pkg::*;

    logic [RS_DEPTH-1:0] push_en;
    logic [RS_DEPTH-1:0] grant;
    logic [RS_DEPTH-1:0] slot_valid;
    logic [RS_DEPTH-1:0] request;
    logic [RS_DEPTH-1:0] e_rs1_bypass;
    logic [RS_DEPTH-1:0] e_rs2_bypass;

    // per-slot fields feeding the issue mux
    rob_tag_t e_rob_tag [RS_DEPTH];
    alu_op_t  e_alu_op  [RS_DEPTH];
    phy_reg_t e_rs1_phy [RS_DEPTH];
    phy_reg_t e_rs2_phy [RS_DEPTH];
    phy_reg_t e_rd_phy  [RS_DEPTH];
    rs_idx_t  sel_idx;

    rs_alloc u_alloc (
        .clk        (clk),
        .arst_n     (arst_n),
        .disp_valid (disp_valid),
        .slot_valid (slot_valid),
        .disp_ready (disp_ready),
        .push_en    (push_en)
    );

    for (genvar g = 0; g < RS_DEPTH; g++) begin : g_slot
        rs_entry u_entry (
            .clk            (clk),
            .arst_n         (arst_n),
            .push_en        (push_en[g]),
            .grant          (grant[g]),
            .disp_rob_tag   (disp_rob_tag),
            .disp_alu_op    (disp_alu_op),
            .disp_rs1_phy   (disp_rs1_phy),
            .disp_rs2_phy   (disp_rs2_phy),
            .disp_rs1_ready (disp_rs1_ready),
            .disp_rs2_ready (disp_rs2_ready),
            .disp_rd_phy    (disp_rd_phy),
            .cdb_valid      (cdb_valid),
            .cdb_rd_phy     (cdb_rd_phy),
            .valid          (slot_valid[g]),
            .request        (request[g]),
            .rob_tag        (e_rob_tag[g]),
            .alu_op         (e_alu_op[g]),
            .rs1_phy        (e_rs1_phy[g]),
            .rs2_phy        (e_rs2_phy[g]),
            .rd_phy         (e_rd_phy[g]),
            .rs1_bypass     (e_rs1_bypass[g]),
            .rs2_bypass     (e_rs2_bypass[g])
        );
    end

    rs_select u_select (
        .clk       (clk),
        .arst_n    (arst_n),
        .push_en   (push_en),
        .request   (request),
        .iss_ready (iss_ready),
        .iss_valid (iss_valid),
        .grant     (grant),
        .sel_idx   (sel_idx)
    );

    // oldest ready slot onto the issue port
    assign iss_rob_tag    = e_rob_tag[sel_idx];
    assign iss_alu_op     = e_alu_op[sel_idx];
    assign iss_rs1_phy    = e_rs1_phy[sel_idx];
    assign iss_rs2_phy    = e_rs2_phy[sel_idx];
    assign iss_rd_phy     = e_rd_phy[sel_idx];
    assign iss_rs1_bypass = e_rs1_bypass[sel_idx];
    assign iss_rs2_bypass = e_rs2_bypass[sel_idx];

endmodule

`default_nettype wire

// File: verif/int_rs_tb.sv
`default_nettype none

module int_rs_tb;

    import rs_cfg_pkg::*;
    import uop_pkg::*;

    localparam int MAX_CYCLES = 3000;  // directed tests plus 2000 random cycles

    typedef struct packed {
        rob_tag_t rob_tag;
        alu_op_t  alu_op;
        phy_reg_t rs1;
        phy_reg_t rs2;
        phy_reg_t rd;
        logic     rdy1;
        logic     rdy2;
    } uop_t;

    typedef struct packed {
        logic hit;
        logic byp1;
        logic byp2;
        int   idx;  // position in the model queue
    } pick_t;

    logic                     clk;
    logic                     arst_n;
    logic                     disp_valid, disp_ready, disp_rs1_ready, disp_rs2_ready;
    rob_tag_t                 disp_rob_tag, iss_rob_tag;
    alu_op_t                  disp_alu_op, iss_alu_op;
    phy_reg_t                 disp_rs1_phy, disp_rs2_phy, disp_rd_phy;
    logic [CDB_WIDTH-1:0]     cdb_valid;
    phy_reg_t [CDB_WIDTH-1:0] cdb_rd_phy;
    logic                     iss_valid, iss_ready, iss_rs1_bypass, iss_rs2_bypass;
    phy_reg_t                 iss_rs1_phy, iss_rs2_phy, iss_rd_phy;

    uop_t model_q[$];  // accepted micro-ops, oldest first
    int   seed;
    int   cycles     = 0;
    int   accept_cnt = 0;
    int   issue_cnt  = 0;
    logic check_en   = 1'b0;

    int_rs uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // any valid broadcast carrying this tag
    function automatic logic live_match(input phy_reg_t tag, input logic [CDB_WIDTH-1:0] vld,
                                        input phy_reg_t [CDB_WIDTH-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (vld[k] && bus[k] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // oldest entry with both sources ready, stored or broadcast right now
    function automatic pick_t expected_issue(input uop_t q[$], input logic [CDB_WIDTH-1:0] vld,
                                             input phy_reg_t [CDB_WIDTH-1:0] bus);
        pick_t p;
        logic  w1;
        logic  w2;
        p = '0;
        for (int i = 0; i < q.size(); i++) begin
            w1 = live_match(q[i].rs1, vld, bus);
            w2 = live_match(q[i].rs2, vld, bus);
            if (!p.hit && (q[i].rdy1 || w1) && (q[i].rdy2 || w2)) begin
                p.hit  = 1'b1;
                p.idx  = i;
                p.byp1 = !q[i].rdy1 && w1 && q[i].rs1 != '0;
                p.byp2 = !q[i].rdy2 && w2 && q[i].rs2 != '0;
            end
        end
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        abort_run($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        disp_valid     = 1'b0;
        disp_rob_tag   = '0;
        disp_alu_op    = '0;
        disp_rs1_phy   = '0;
        disp_rs1_ready = 1'b0;
        disp_rs2_phy   = '0;
        disp_rs2_ready = 1'b0;
        disp_rd_phy    = '0;
        cdb_valid      = '0;
        cdb_rd_phy     = '0;
    endtask

    // drive one micro-op and hold it until the station takes it
    task automatic put_uop(input rob_tag_t rob, input phy_reg_t rs1, input logic rdy1,
                           input phy_reg_t rs2, input logic rdy2);
        int target;
        target         = accept_cnt + 1;
        disp_valid     = 1'b1;
        disp_rob_tag   = rob;
        disp_alu_op    = rob[3:0];
        disp_rs1_phy   = rs1;
        disp_rs1_ready = rdy1;
        disp_rs2_phy   = rs2;
        disp_rs2_ready = rdy2;
        disp_rd_phy    = {1'b1, rob};
        while (accept_cnt < target) begin
            next_cycle();
        end
        disp_valid = 1'b0;
    endtask

    // open the issue port until n more micro-ops have left
    task automatic wait_issue(input int n);
        int target;
        target    = issue_cnt + n;
        iss_ready = 1'b1;
        while (issue_cnt < target) begin
            next_cycle();
        end
        iss_ready = 1'b0;
    endtask

    // reference model, moves on the same edge as the DUT
    always @(posedge clk) begin
        pick_t p;
        uop_t  u;
        logic  take;
        if (arst_n) begin
            take = disp_valid && (model_q.size() < RS_DEPTH);
            p = expected_issue(model_q, cdb_valid, cdb_rd_phy);
            if (p.hit && iss_ready) begin
                model_q.delete(p.idx);
                issue_cnt++;
            end
            for (int i = 0; i < model_q.size(); i++) begin
                u = model_q[i];
                u.rdy1 = u.rdy1 || live_match(u.rs1, cdb_valid, cdb_rd_phy);
                u.rdy2 = u.rdy2 || live_match(u.rs2, cdb_valid, cdb_rd_phy);
                model_q[i] = u;
            end
            if (take) begin
                u.rob_tag = disp_rob_tag;
                u.alu_op  = disp_alu_op;
                u.rs1     = disp_rs1_phy;
                u.rs2     = disp_rs2_phy;
                u.rd      = disp_rd_phy;
                u.rdy1    = disp_rs1_ready || disp_rs1_phy == '0
                            || live_match(disp_rs1_phy, cdb_valid, cdb_rd_phy);
                u.rdy2    = disp_rs2_ready || disp_rs2_phy == '0
                            || live_match(disp_rs2_phy, cdb_valid, cdb_rd_phy);
                model_q.push_back(u);
                accept_cnt++;
            end
        end
    end

    // compare mid-cycle while inputs and outputs are stable
    always @(negedge clk) begin
        pick_t p;
        uop_t  e;
        logic  exp_ready;
        if (check_en) begin
            p = expected_issue(model_q, cdb_valid, cdb_rd_phy);
            exp_ready = model_q.size() < RS_DEPTH;
            assert (disp_ready === exp_ready)
                else mismatch("disp_ready", 32'(exp_ready), 32'(disp_ready));
            assert (iss_valid === p.hit) else mismatch("iss_valid", 32'(p.hit), 32'(iss_valid));
            if (p.hit) begin
                e = model_q[p.idx];
                assert (iss_rob_tag === e.rob_tag)
                    else mismatch("iss_rob_tag", 32'(e.rob_tag), 32'(iss_rob_tag));
                assert (iss_alu_op === e.alu_op)
                    else mismatch("iss_alu_op", 32'(e.alu_op), 32'(iss_alu_op));
                assert (iss_rs1_phy === e.rs1)
                    else mismatch("iss_rs1_phy", 32'(e.rs1), 32'(iss_rs1_phy));
                assert (iss_rs2_phy === e.rs2)
                    else mismatch("iss_rs2_phy", 32'(e.rs2), 32'(iss_rs2_phy));
                assert (iss_rd_phy === e.rd)
                    else mismatch("iss_rd_phy", 32'(e.rd), 32'(iss_rd_phy));
                assert (iss_rs1_bypass === p.byp1)
                    else mismatch("iss_rs1_bypass", 32'(p.byp1), 32'(iss_rs1_bypass));
                assert (iss_rs2_bypass === p.byp2)
                    else mismatch("iss_rs2_bypass", 32'(p.byp2), 32'(iss_rs2_bypass));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        logic [31:0] r;
        seed      = 32'h9be555a4;
        arst_n    = 1'b0;
        iss_ready = 1'b0;
        idle_inputs();
        repeat (4) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        check_en = 1'b1;
        repeat (2) next_cycle();  // empty station, nothing driven yet

        // ready micro-op shown from the next cycle, held by back-pressure
        put_uop(5'd1, 6'd3, 1'b1, 6'd4, 1'b1);
        repeat (2) next_cycle();
        wait_issue(1);

        for (int k = 0; k < CDB_WIDTH; k++) begin
            put_uop(5'(2 + k), 6'(10 + k), 1'b0, 6'd0, 1'b0);  // rs2 on the zero register
            next_cycle();
            cdb_valid[k] = 1'b1;
            cdb_rd_phy[k] = 6'(10 + k);
            cdb_valid[(k + 1) % CDB_WIDTH] = 1'b1;  // zero tag on the other port
            cdb_rd_phy[(k + 1) % CDB_WIDTH] = '0;
            wait_issue(1);
            cdb_valid = '0;
            cdb_valid[k] = 1'b1;
            cdb_rd_phy[k] = 6'(20 + k);
            put_uop(5'(4 + k), 6'd5, 1'b1, 6'(20 + k), 1'b0);  // woken during the push
            cdb_valid = '0;
            wait_issue(1);
        end

        // age order across slots, oldest sits in a higher slot than the youngest
        put_uop(5'd10, 6'd30, 1'b0, 6'd0, 1'b1);
        put_uop(5'd11, 6'd1, 1'b1, 6'd2, 1'b1);
        put_uop(5'd12, 6'd31, 1'b0, 6'd3, 1'b1);
        wait_issue(1);
        put_uop(5'd13, 6'd4, 1'b1, 6'd5, 1'b1);  // reuses the freed slot
        repeat (2) next_cycle();
        cdb_valid[0] = 1'b1;
        cdb_rd_phy[0] = 6'd31;
        next_cycle();
        cdb_valid = '0;
        repeat (2) next_cycle();
        cdb_valid[1] = 1'b1;
        cdb_rd_phy[1] = 6'd30;
        next_cycle();
        cdb_valid = '0;
        repeat (2) next_cycle();
        wait_issue(3);

        // fill the station, then one issue lets the stalled dispatch in
        for (int k = 0; k < RS_DEPTH; k++) begin
            put_uop(5'(16 + k), 6'(k + 1), 1'b1, 6'(k + 5), 1'b1);
        end
        fork
            put_uop(5'd24, 6'd9, 1'b1, 6'd0, 1'b0);
            begin
                repeat (3) next_cycle();
                wait_issue(1);
            end
        join
        wait_issue(RS_DEPTH);

        repeat (2000) begin
            r = $random(seed);
            disp_valid     = r[0];
            disp_rob_tag   = r[8:4];
            disp_alu_op    = r[12:9];
            disp_rs1_phy   = {2'b00, r[16:13]};
            disp_rs1_ready = r[17] & r[18];
            disp_rs2_phy   = {2'b00, r[22:19]};
            disp_rs2_ready = r[23] & r[24];
            disp_rd_phy    = {2'b00, r[28:25]};
            iss_ready      = r[29] | r[30];
            for (int k = 0; k < CDB_WIDTH; k++) begin
                r = $random(seed);
                cdb_valid[k]  = r[0];
                cdb_rd_phy[k] = {2'b00, r[4:1]};
            end
            next_cycle();
        end

        idle_inputs();
        iss_ready = 1'b0;
        repeat (2) next_cycle();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/rs_cfg_pkg.sv
hdl/uop_pkg.sv
hdl/rs_entry.sv
hdl/rs_alloc.sv
hdl/rs_select.sv
hdl/int_rs.sv
verif/int_rs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the reservation station testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module int_rs_tb -Mdir "$OBJ" -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$OBJ/Vint_rs_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
